/* filelist.f */
hdl/lb_pkg.sv
hdl/lb_port.sv
hdl/status_counters.sv
hdl/mirror_ram.sv
hdl/lb_read_mux.sv
hdl/led_pwm.sv
hdl/lb_slave_top.sv
test/lb_slave_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the local-bus slave testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module lb_slave_tb -o lb_slave_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/lb_slave_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

exit 0

/* test/lb_slave_tb.sv */
// Testbench for the local-bus slave covering ID, mirror, control, fault, PWM and uptime
`timescale 1ns/1ps

module lb_slave_tb;
	import lb_pkg::*;

	localparam int TIMEOUT_CYCLES = 20000;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic [LB_AW-1:0] addr = '0;
	logic control_strobe = 1'b0;
	logic control_rd = 1'b0;
	logic [LB_DW-1:0] data_out = '0;
	logic fault = 1'b0;
	logic [3:0] pins = 4'd0;
	logic [LB_DW-1:0] data_in;
	logic led_user_mode;
	logic led1;
	logic led2;
	logic [7:0] config_out;

	// Reference model state
	logic [LB_DW-1:0] ref_mirror [0:31];
	logic [FAULT_W-1:0] ref_fault = '0;
	logic [3:0] ref_pins = 4'd0;

	logic [LB_DW-1:0] exp_q [$];
	bit chk_q [$];
	logic [LB_DW-1:0] captured [$];
	logic [1:0] rd_hist = 2'b00;
	logic [LB_DW-1:0] exp_word;
	bit exp_chk;
	string test_name = "reset";
	bit failed = 1'b0;
	int cycle_count = 0;

	lb_slave_top i_lb_slave_top (
		.clk(clk), .reset(reset), .addr(addr), .control_strobe(control_strobe),
		.control_rd(control_rd), .data_out(data_out), .fault(fault), .pins(pins),
		.data_in(data_in), .led_user_mode(led_user_mode), .led1(led1), .led2(led2),
		.config_out(config_out)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("STATUS: FAIL");
			$fatal(1, "run stopped by timeout");
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			failed = 1'b1;
			$display("** Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic [31:0] rand_word();
		return $urandom;
	endfunction

	// Random middle address bits must not change the decode
	function automatic logic [LB_AW-1:0] make_addr(input logic [7:0] blk, input logic [4:0] low);
		logic [31:0] r;
		r = rand_word();
		return {blk, r[10:0], low};
	endfunction

	// Expected read word from the address map and the model state
	function automatic logic [LB_DW-1:0] expected_word(input logic [LB_AW-1:0] a);
		if (a[23:16] == 8'h05) begin
			return ref_mirror[a[4:0]];
		end else if (a[23:16] != 8'h00) begin
			return 32'hdeadbeef;
		end
		case (a[3:0])
			4'd0, 4'd1, 4'd2, 4'd3: return HELLO_WORDS[a[1:0]];
			4'd4: return {16'd0, ref_fault};
			4'd6: return {28'd0, ref_pins};
			default: return "zzzz";
		endcase
	endfunction

	task automatic start_read(input logic [LB_AW-1:0] a, input bit check);
		@(posedge clk);
		#2;
		addr = a;
		control_strobe = 1'b1;
		control_rd = 1'b1;
		exp_q.push_back(expected_word(a));
		chk_q.push_back(check);
	endtask

	task automatic write_bus(input logic [LB_AW-1:0] a, input logic [LB_DW-1:0] d);
		@(posedge clk);
		#2;
		addr = a;
		data_out = d;
		control_strobe = 1'b1;
		control_rd = 1'b0;
		if (a[23:16] == 8'h05) begin
			ref_mirror[a[4:0]] = d;
			if (a[4:0] == 5'd4) begin
				ref_fault = '0;
			end
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
			control_strobe = 1'b0;
			control_rd = 1'b0;
		end
	endtask

	task automatic wait_reads_done();
		idle_cycles(1);
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	// Read data is due two cycles after the strobe is sampled
	always @(negedge clk) begin
		if (rd_hist[1]) begin
			if (exp_q.size() == 0) begin
				$display("Read data arrived with no expected word queued in %s", test_name);
				$display("STATUS: FAIL");
				$fatal(1, "unexpected read");
			end
			exp_word = exp_q.pop_front();
			exp_chk = chk_q.pop_front();
			if (exp_chk) begin
				check_value(test_name, exp_word, data_in);
			end else begin
				captured.push_back(data_in);
			end
		end
		rd_hist[1] = rd_hist[0];
		rd_hist[0] = control_strobe & control_rd;
	end

	initial begin
		logic [31:0] r;
		logic [7:0] blk;
		logic [7:0] d1;
		logic [7:0] d2;
		logic [31:0] c1;
		logic [31:0] c2;
		void'($urandom(89581));
		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;

		test_name = "id_defaults";
		for (int i = 0; i < 16; i++) begin
			if (i != 5) begin
				start_read(make_addr(8'h00, {1'b0, i[3:0]}), 1'b1);
			end
		end
		repeat (20) begin
			r = rand_word();
			blk = (r[7:0] == 8'h05 || r[7:0] == 8'h00) ? 8'h06 : r[7:0];
			start_read(make_addr(blk, r[12:8]), 1'b1);
		end
		wait_reads_done();

		test_name = "mirror";
		for (int i = 0; i < 48; i++) begin
			r = rand_word();
			write_bus(make_addr(8'h05, (i < 32) ? i[4:0] : r[4:0]), rand_word());
		end
		for (int i = 0; i < 32; i++) begin
			start_read(make_addr(8'h05, i[4:0]), 1'b1);
		end
		wait_reads_done();

		test_name = "control";
		repeat (4) begin
			r = rand_word();
			write_bus(make_addr(8'h05, 5'd1), r);
			idle_cycles(1);
			@(negedge clk);
			check_value({test_name, " led_user_mode"}, {31'd0, r[0]}, {31'd0, led_user_mode});
			r = rand_word();
			write_bus(make_addr(8'h05, 5'd8), r);
			idle_cycles(1);
			@(negedge clk);
			check_value({test_name, " config_out"}, {24'd0, r[7:0]}, {24'd0, config_out});
		end

		test_name = "fault";
		repeat (40) begin
			r = rand_word();
			@(posedge clk);
			#2;
			fault = r[0];
			if (r[0]) ref_fault = ref_fault + 16'd1;
		end
		@(posedge clk);
		#2;
		fault = 1'b0;
		idle_cycles(2);
		start_read(make_addr(8'h00, 5'd4), 1'b1);
		wait_reads_done();
		write_bus(make_addr(8'h05, 5'd4), rand_word());
		idle_cycles(2);
		start_read(make_addr(8'h00, 5'd4), 1'b1);
		wait_reads_done();

		test_name = "pwm";
		r = rand_word();
		d1 = r[7:0];
		d2 = r[15:8];
		write_bus(make_addr(8'h05, 5'd2), {24'd0, d1});
		write_bus(make_addr(8'h05, 5'd3), {24'd0, d2});
		idle_cycles(3);
		c1 = 32'd0;
		c2 = 32'd0;
		repeat (1024) begin
			@(negedge clk);
			if (led1) c1 = c1 + 32'd1;
			if (led2) c2 = c2 + 32'd1;
		end
		check_value("pwm led1", {24'd0, d1} * 32'd4, c1);
		check_value("pwm led2", {24'd0, d2} * 32'd4, c2);

		test_name = "uptime";
		start_read(make_addr(8'h00, 5'd5), 1'b0);
		idle_cycles(3071);
		start_read(make_addr(8'h00, 5'd5), 1'b0);
		wait_reads_done();
		check_value("uptime", captured[0] + 32'd3, captured[1]);

		test_name = "pins";
		repeat (4) begin
			r = rand_word();
			@(posedge clk);
			#2;
			pins = r[3:0];
			ref_pins = r[3:0];
			idle_cycles(2);
			start_read(make_addr(8'h00, 5'd6), 1'b1);
			wait_reads_done();
		end

		if (failed) begin
			$display("STATUS: FAIL");
			$fatal(1, "checks failed");
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

/* hdl/lb_slave_top.sv */
// Top level of the local-bus slave that wires bus port, status, mirror, read mux and LED PWM
`timescale 1ns/1ps

module lb_slave_top (
	input  logic                     clk,
	input  logic                     reset,
	input  logic [lb_pkg::LB_AW-1:0] addr,
	input  logic                     control_strobe,
	input  logic                     control_rd,
	input  logic [lb_pkg::LB_DW-1:0] data_out,
	input  logic                     fault,
	input  logic [3:0]               pins,
	output logic [lb_pkg::LB_DW-1:0] data_in,
	output logic                     led_user_mode,
	output logic                     led1,
	output logic                     led2,
	output logic [7:0]               config_out
);
	import lb_pkg::*;

	logic rd_stage1;
	logic [3:0] bank_index;
	logic rd_stage2;
	logic [LB_AW-1:0] addr_stage2;
	logic wr_en;
	logic [MIRROR_AW-1:0] wr_addr;
	logic [LB_DW-1:0] wr_data;
	logic fault_clr;
	logic [7:0] led1_duty;
	logic [7:0] led2_duty;
	logic tick;
	logic [FAULT_W-1:0] fault_count;
	logic [31:0] uptime;
	logic [3:0] pins_sampled;
	logic [LB_DW-1:0] mirror_word;

	lb_port i_lb_port (
		.clk(clk), .reset(reset), .addr(addr), .control_strobe(control_strobe),
		.control_rd(control_rd), .data_out(data_out), .rd_stage1(rd_stage1),
		.bank_index(bank_index), .rd_stage2(rd_stage2), .addr_stage2(addr_stage2),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .fault_clr(fault_clr),
		.led1_duty(led1_duty), .led2_duty(led2_duty),
		.led_user_mode(led_user_mode), .config_out(config_out)
	);

	status_counters i_status_counters (
		.clk(clk), .reset(reset), .fault(fault), .fault_clr(fault_clr), .tick(tick),
		.pins(pins), .fault_count(fault_count), .uptime(uptime),
		.pins_sampled(pins_sampled)
	);

	// Read address is the live bus address like the write side
	mirror_ram #(.aw(MIRROR_AW)) i_mirror_ram (
		.clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_addr(addr[MIRROR_AW-1:0]), .mirror_word(mirror_word)
	);

	lb_read_mux i_lb_read_mux (
		.clk(clk), .reset(reset), .rd_stage1(rd_stage1), .bank_index(bank_index),
		.rd_stage2(rd_stage2), .addr_stage2(addr_stage2), .fault_count(fault_count),
		.uptime(uptime), .pins_sampled(pins_sampled), .mirror_word(mirror_word),
		.data_in(data_in)
	);

	led_pwm i_led_pwm (
		.clk(clk), .reset(reset), .led1_duty(led1_duty), .led2_duty(led2_duty),
		.led1(led1), .led2(led2), .tick(tick)
	);

endmodule

/* hdl/led_pwm.sv */
// LED dimmer built on a free-running counter whose wrap also gives the uptime tick
`timescale 1ns/1ps

module led_pwm (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] led1_duty,
	input  logic [7:0] led2_duty,
	output logic       led1,
	output logic       led2,
	output logic       tick
);
	import lb_pkg::*;

	logic [PWM_CW-1:0] pwm_cc;

	// Counter carry-out is the tick once per period
	always_ff @(posedge clk) begin
		if (reset) begin
			{tick, pwm_cc} <= '0;
		end else begin
			{tick, pwm_cc} <= pwm_cc + 1'b1;
		end
	end

	// Duty scaled by 4 to fill the 10-bit period
	always_ff @(posedge clk) begin
		if (reset) begin
			led1 <= 1'b0;
			led2 <= 1'b0;
		end else begin
			led1 <= pwm_cc < {led1_duty, 2'b00};
			led2 <= pwm_cc < {led2_duty, 2'b00};
		end
	end

	a_tick_single: assert property (@(posedge clk) disable iff (reset)
		tick |=> !tick);

endmodule

/* hdl/lb_read_mux.sv */
// Two-stage read pipeline that picks a bank word and then the word of the addressed block
`timescale 1ns/1ps

module lb_read_mux (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       rd_stage1,
	input  logic [3:0]                 bank_index,
	input  logic                       rd_stage2,
	input  logic [lb_pkg::LB_AW-1:0]   addr_stage2,
	input  logic [lb_pkg::FAULT_W-1:0] fault_count,
	input  logic [31:0]                uptime,
	input  logic [3:0]                 pins_sampled,
	input  logic [lb_pkg::LB_DW-1:0]   mirror_word,
	output logic [lb_pkg::LB_DW-1:0]   data_in
);
	import lb_pkg::*;

	logic [LB_DW-1:0] bank_word;
	logic [7:0] blk_stage2;

	assign blk_stage2 = addr_stage2[LB_AW-1 -: 8];

	// First read cycle
	always_ff @(posedge clk) begin
		if (rd_stage1) begin
			case (bank_index)
				REG_HELLO0: bank_word <= HELLO_WORDS[0];
				REG_HELLO1: bank_word <= HELLO_WORDS[1];
				REG_HELLO2: bank_word <= HELLO_WORDS[2];
				REG_HELLO3: bank_word <= HELLO_WORDS[3];
				REG_FAULT: bank_word <= {{(LB_DW-FAULT_W){1'b0}}, fault_count};
				REG_UPTIME: bank_word <= uptime;
				REG_PINS: bank_word <= {{(LB_DW-4){1'b0}}, pins_sampled};
				default: bank_word <= BANK_EMPTY;
			endcase
		end
	end

	// Second read cycle decodes the upper address byte
	always_ff @(posedge clk) begin
		if (reset) begin
			data_in <= '0;
		end else if (rd_stage2) begin
			case (blk_stage2)
				BLK_REGS: data_in <= bank_word;
				BLK_LOCAL: data_in <= mirror_word;
				default: data_in <= BUS_EMPTY;
			endcase
		end
	end

	// Read data must hold between completed reads
	a_data_hold: assert property (@(posedge clk) disable iff (reset)
		!$stable(data_in) |-> $past(rd_stage2));

endmodule

/* hdl/mirror_ram.sv */
// Simple dual-port memory that records local writes and reads them back one cycle later
`timescale 1ns/1ps

module mirror_ram #(
	parameter int aw = lb_pkg::MIRROR_AW
) (
	input  logic                     clk,
	input  logic                     wr_en,
	input  logic [aw-1:0]            wr_addr,
	input  logic [lb_pkg::LB_DW-1:0] wr_data,
	input  logic [aw-1:0]            rd_addr,
	output logic [lb_pkg::LB_DW-1:0] mirror_word
);
	import lb_pkg::*;

	logic [LB_DW-1:0] mem [0:(2**aw)-1];

	// Write port
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Free-running registered read port whose word is ready for the second read stage
	always_ff @(posedge clk) begin
		mirror_word <= mem[rd_addr];
	end

endmodule

/* hdl/status_counters.sv */
// Status sources for the read-only bank with fault counter, uptime and sampled pins
`timescale 1ns/1ps

module status_counters (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       fault,
	input  logic                       fault_clr,
	input  logic                       tick,
	input  logic [3:0]                 pins,
	output logic [lb_pkg::FAULT_W-1:0] fault_count,
	output logic [31:0]                uptime,
	output logic [3:0]                 pins_sampled
);
	import lb_pkg::*;

	// Wrapping fault counter where a clear beats a same-cycle fault
	always_ff @(posedge clk) begin
		if (reset) begin
			fault_count <= '0;
		end else if (fault_clr) begin
			fault_count <= '0;
		end else if (fault) begin
			fault_count <= fault_count + 1'b1;
		end
	end

	// One count per PWM period
	always_ff @(posedge clk) begin
		if (reset) begin
			uptime <= 32'd0;
		end else if (tick) begin
			uptime <= uptime + 32'd1;
		end
	end

	// Pins come from outside and are registered once
	always_ff @(posedge clk) begin
		if (reset) begin
			pins_sampled <= 4'd0;
		end else begin
			pins_sampled <= pins;
		end
	end

endmodule

/* hdl/lb_port.sv */
// Bus front end that separates reads from local writes, holds control registers, delays reads
`timescale 1ns/1ps

module lb_port (
	input  logic                     clk,
	input  logic                     reset,
	input  logic [lb_pkg::LB_AW-1:0] addr,
	input  logic                     control_strobe,
	input  logic                     control_rd,
	input  logic [lb_pkg::LB_DW-1:0] data_out,
	output logic                     rd_stage1,
	output logic [3:0]               bank_index,
	output logic                     rd_stage2,
	output logic [lb_pkg::LB_AW-1:0] addr_stage2,
	output logic                     wr_en,
	output logic [lb_pkg::MIRROR_AW-1:0] wr_addr,
	output logic [lb_pkg::LB_DW-1:0] wr_data,
	output logic                     fault_clr,
	output logic [7:0]               led1_duty,
	output logic [7:0]               led2_duty,
	output logic                     led_user_mode,
	output logic [7:0]               config_out
);
	import lb_pkg::*;

	logic [4:0] wr_offset;

	// First read stage works straight off the bus
	assign rd_stage1 = control_strobe & control_rd;
	assign bank_index = addr[3:0];

	// Local writes go to block 5 and are mirrored as well
	assign wr_en = control_strobe & ~control_rd & (addr[LB_AW-1 -: 8] == BLK_LOCAL);
	assign wr_addr = addr[MIRROR_AW-1:0];
	assign wr_data = data_out;
	assign wr_offset = addr[4:0];

	// Second read stage sees strobe and address one cycle late
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_stage2 <= 1'b0;
			addr_stage2 <= '0;
		end else begin
			rd_stage2 <= rd_stage1;
			addr_stage2 <= addr;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			led_user_mode <= 1'b0;
			led1_duty <= 8'd0;
			led2_duty <= 8'd0;
			config_out <= 8'd0;
			fault_clr <= 1'b0;
		end else begin
			// Clear pulse follows the write by one cycle
			fault_clr <= wr_en && (wr_offset == WR_FAULT_CLR);
			if (wr_en) begin
				case (wr_offset)
					WR_LED_USER: led_user_mode <= data_out[0];
					WR_LED1_DUTY: led1_duty <= data_out[7:0];
					WR_LED2_DUTY: led2_duty <= data_out[7:0];
					WR_CONFIG: config_out <= data_out[7:0];
					default: ;
				endcase
			end
		end
	end

	// The decode above relies on a clean address whenever the master strobes
	a_addr_known: assert property (@(posedge clk) disable iff (reset)
		control_strobe |-> !$isunknown(addr));

endmodule

/* hdl/lb_pkg.sv */
// Shared local-bus widths, address map, register-bank indices and PWM sizing for the slave
package lb_pkg;

	// Local bus widths
	localparam int LB_AW = 24;
	localparam int LB_DW = 32;

	// Block numbers taken from the upper address byte
	localparam logic [7:0] BLK_REGS = 8'h00;
	localparam logic [7:0] BLK_LOCAL = 8'h05;

	// Read-only register bank indices in addr[3:0]
	localparam logic [3:0] REG_HELLO0 = 4'd0;
	localparam logic [3:0] REG_HELLO1 = 4'd1;
	localparam logic [3:0] REG_HELLO2 = 4'd2;
	localparam logic [3:0] REG_HELLO3 = 4'd3;
	localparam logic [3:0] REG_FAULT = 4'd4;
	localparam logic [3:0] REG_UPTIME = 4'd5;
	localparam logic [3:0] REG_PINS = 4'd6;

	// ASCII identification words in read-back order
	localparam logic [LB_DW-1:0] HELLO_WORDS [0:3] = '{"Hell", "o wo", "rld!", "(::)"};

	// Fill words for unused bank slots and unused blocks
	localparam logic [LB_DW-1:0] BANK_EMPTY = "zzzz";
	localparam logic [LB_DW-1:0] BUS_EMPTY = 32'hdeadbeef;

	// Local-write offsets in addr[4:0]
	localparam logic [4:0] WR_LED_USER = 5'd1;
	localparam logic [4:0] WR_LED1_DUTY = 5'd2;
	localparam logic [4:0] WR_LED2_DUTY = 5'd3;
	localparam logic [4:0] WR_FAULT_CLR = 5'd4;
	localparam logic [4:0] WR_CONFIG = 5'd8;

	// Mirror depth is 2**MIRROR_AW words
	localparam int MIRROR_AW = 5;

	// PWM period is 2**PWM_CW cycles
	localparam int PWM_CW = 10;
	localparam int FAULT_W = 16;

endpackage
